// File: hdl/fxp_pkg.sv
// --------------------------------------------------
// Q8.8 fixed-point widths, value types and operation
// codes shared by the math unit and its testbench.
// --------------------------------------------------
package fxp_pkg;

    localparam int int_width  = 8;
    localparam int frac_width = 8;
    localparam int fxp_width  = int_width + frac_width;

    // Signed Q8.8 value.
    typedef logic signed [fxp_width-1:0] fxp_t;

    // Integer exponent taken from the top bits of an operand.
    typedef logic [int_width-1:0] fxp_exp_t;

    // Unsigned magnitude product, wide enough for any two operands.
    typedef logic [2*fxp_width-1:0] fxp_prod_t;

    localparam fxp_t fxp_one = fxp_t'(1 << frac_width);

    typedef enum logic {
        OP_MUL = 1'b0,
        OP_POW = 1'b1
    } fxp_op_e;

endpackage

// File: hdl/fxp_job_if.sv
// --------------------------------------------------
// One arithmetic job and its result between a
// requester and a worker, with a done pulse.
// --------------------------------------------------
interface fxp_job_if;

    logic          req_valid;
    logic          req_ready;
    fxp_pkg::fxp_t a;
    fxp_pkg::fxp_t b;
    logic          done;
    // Held by the worker after done until its next job.
    fxp_pkg::fxp_t result;

    modport requester (
        output req_valid,
        output a,
        output b,
        input  req_ready,
        input  done,
        input  result
    );

    modport worker (
        input  req_valid,
        input  a,
        input  b,
        output req_ready,
        output done,
        output result
    );

endinterface

// File: hdl/fxp_mul.sv
// --------------------------------------------------
// Sequential shift-add Q8.8 multiplier, one bit of
// the multiplier per cycle, worker side of a job.
// --------------------------------------------------
module fxp_mul (
    input  logic      clk,
    input  logic      rst,
    fxp_job_if.worker job
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_FINISH
    } state_e;

    state_e                                state;
    logic [$clog2(fxp_pkg::fxp_width)-1:0] step;
    logic [fxp_pkg::fxp_width-1:0]         mplier;
    fxp_pkg::fxp_prod_t                    mcand;
    fxp_pkg::fxp_prod_t                    acc;
    fxp_pkg::fxp_prod_t                    prod_signed;
    logic                                  neg;
    logic                                  done_q;
    fxp_pkg::fxp_t                         res_q;
    fxp_pkg::fxp_t                         neg_a;
    fxp_pkg::fxp_t                         neg_b;
    logic [fxp_pkg::fxp_width-1:0]         mag_a;
    logic [fxp_pkg::fxp_width-1:0]         mag_b;
    logic                                  accept;

    assign accept = job.req_valid && job.req_ready;

    // Magnitudes, -32768 maps onto 0x8000 which still fits unsigned.
    assign neg_a = -job.a;
    assign neg_b = -job.b;
    assign mag_a = job.a[fxp_pkg::fxp_width-1] ? neg_a : job.a;
    assign mag_b = job.b[fxp_pkg::fxp_width-1] ? neg_b : job.b;

    // Two's complement product, so dropping the low bits rounds toward minus infinity.
    assign prod_signed = neg ? -acc : acc;

    assign job.req_ready = (state == ST_IDLE) && !done_q;
    assign job.done      = done_q;
    assign job.result    = res_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ST_IDLE;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state <= ST_RUN;
                    end
                end
                ST_RUN: begin
                    // Last multiplier bit.
                    if (&step) begin
                        state <= ST_FINISH;
                    end
                end
                ST_FINISH: begin
                    state  <= ST_IDLE;
                    done_q <= 1'b1;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            ST_IDLE: begin
                if (accept) begin
                    mcand  <= fxp_pkg::fxp_prod_t'(mag_a);
                    mplier <= mag_b;
                    acc    <= '0;
                    step   <= '0;
                    neg    <= job.a[fxp_pkg::fxp_width-1] ^ job.b[fxp_pkg::fxp_width-1];
                end
            end
            ST_RUN: begin
                if (mplier[0]) begin
                    acc <= acc + mcand;
                end
                mcand  <= mcand << 1;
                mplier <= mplier >> 1;
                step   <= step + 1'b1;
            end
            ST_FINISH: begin
                res_q <= prod_signed[fxp_pkg::fxp_width+fxp_pkg::frac_width-1 -: fxp_pkg::fxp_width];
            end
            default: begin
            end
        endcase
    end

    // Busy for the whole job, done exactly 17 cycles after acceptance.
    assert property (@(posedge clk) disable iff (rst)
        accept |=> !job.req_ready [*17] ##1 (job.done && !job.req_ready));

endmodule

// File: hdl/fxp_pow.sv
// --------------------------------------------------
// Power unit: a raised to the integer part of b by
// repeated Q8.8 multiplies on a private multiplier.
// --------------------------------------------------
module fxp_pow (
    input  logic      clk,
    input  logic      rst,
    fxp_job_if.worker job
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CHECK,
        ST_START,
        ST_WAIT
    } state_e;

    state_e             state;
    fxp_pkg::fxp_t      base;
    fxp_pkg::fxp_exp_t  count;
    fxp_pkg::fxp_t      acc;
    logic               done_q;
    logic               accept;

    fxp_job_if mul_job ();

    fxp_mul i_fxp_mul (
        .clk (clk),
        .rst (rst),
        .job (mul_job)
    );

    assign accept = job.req_valid && job.req_ready;

    assign job.req_ready = (state == ST_IDLE) && !done_q;
    assign job.done      = done_q;
    assign job.result    = acc;

    // Running result times the base.
    assign mul_job.req_valid = (state == ST_START);
    assign mul_job.a         = acc;
    assign mul_job.b         = base;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ST_IDLE;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state <= ST_CHECK;
                    end
                end
                ST_CHECK: begin
                    if (count == '0) begin
                        state  <= ST_IDLE;
                        done_q <= 1'b1;
                    end else begin
                        state <= ST_START;
                    end
                end
                ST_START: begin
                    if (mul_job.req_ready) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (mul_job.done) begin
                        state <= ST_CHECK;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && accept) begin
            base  <= job.a;
            count <= job.b[fxp_pkg::fxp_width-1 -: fxp_pkg::int_width];
            acc   <= fxp_pkg::fxp_one;
        end
        if (state == ST_START && mul_job.req_ready) begin
            count <= count - 1'b1;
        end
        if (state == ST_WAIT && mul_job.done) begin
            acc <= mul_job.result;
        end
    end

    // Outside a new job the counter only ever steps down by one from a non-zero value.
    assert property (@(posedge clk) disable iff (rst)
        ($changed(count) && !$past(accept)) |->
            ($past(count) != '0 && count == $past(count) - 1'b1));

endmodule

// File: hdl/fxp_math_ctrl.sv
// --------------------------------------------------
// Accepts one request, runs it on the multiplier or
// the power unit and holds the result for output.
// --------------------------------------------------
module fxp_math_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    output logic                in_ready,
    input  fxp_pkg::fxp_op_e    op,
    input  fxp_pkg::fxp_t       a,
    input  fxp_pkg::fxp_t       b,
    output logic                out_valid,
    input  logic                out_ready,
    output fxp_pkg::fxp_t       result,
    fxp_job_if.requester        mul,
    fxp_job_if.requester        pow
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DISPATCH,
        ST_WAIT,
        ST_OUTPUT
    } state_e;

    state_e             state;
    fxp_pkg::fxp_op_e   op_q;
    fxp_pkg::fxp_t      a_q;
    fxp_pkg::fxp_t      b_q;
    fxp_pkg::fxp_t      res_q;
    logic               in_ready_q;
    logic               is_pow;
    logic               sel_ready;
    logic               sel_done;
    fxp_pkg::fxp_t      sel_result;

    assign is_pow     = (op_q == fxp_pkg::OP_POW);
    assign sel_ready  = is_pow ? pow.req_ready : mul.req_ready;
    assign sel_done   = is_pow ? pow.done : mul.done;
    assign sel_result = is_pow ? pow.result : mul.result;

    // Only the selected worker sees a request.
    assign mul.req_valid = (state == ST_DISPATCH) && !is_pow;
    assign pow.req_valid = (state == ST_DISPATCH) && is_pow;
    assign mul.a         = a_q;
    assign mul.b         = b_q;
    assign pow.a         = a_q;
    assign pow.b         = b_q;

    assign in_ready  = in_ready_q;
    assign out_valid = (state == ST_OUTPUT);
    assign result    = res_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            in_ready_q <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (in_valid && in_ready_q) begin
                        state      <= ST_DISPATCH;
                        in_ready_q <= 1'b0;
                    end else begin
                        in_ready_q <= 1'b1;
                    end
                end
                ST_DISPATCH: begin
                    if (sel_ready) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (sel_done) begin
                        state <= ST_OUTPUT;
                    end
                end
                ST_OUTPUT: begin
                    // Back-pressure holds the unit here, so no new input is taken.
                    if (out_ready) begin
                        state      <= ST_IDLE;
                        in_ready_q <= 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && in_valid && in_ready_q) begin
            op_q <= op;
            a_q  <= a;
            b_q  <= b;
        end
        if (state == ST_WAIT && sel_done) begin
            res_q <= sel_result;
        end
    end

    // A stalled result stays valid and unchanged.
    assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(result)));

    // Never ready for a new request while a result is pending.
    assert property (@(posedge clk) disable iff (rst)
        !(in_ready && out_valid));

endmodule

// File: hdl/fxp_math_unit.sv
// --------------------------------------------------
// Q8.8 math unit top: multiply and integer power
// behind valid/ready input and output ports.
// --------------------------------------------------
module fxp_math_unit (
    input  logic          clk,
    input  logic          rst,
    input  logic          in_valid,
    output logic          in_ready,
    input  logic [0:0]    op,
    input  fxp_pkg::fxp_t a,
    input  fxp_pkg::fxp_t b,
    output logic          out_valid,
    input  logic          out_ready,
    output fxp_pkg::fxp_t result
);

    fxp_pkg::fxp_op_e op_e;

    // 0 selects multiply, 1 selects power.
    assign op_e = fxp_pkg::fxp_op_e'(op);

    fxp_job_if ctrl_mul ();
    fxp_job_if ctrl_pow ();

    fxp_math_ctrl i_fxp_math_ctrl (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .op        (op_e),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .result    (result),
        .mul       (ctrl_mul),
        .pow       (ctrl_pow)
    );

    fxp_mul i_fxp_mul (
        .clk (clk),
        .rst (rst),
        .job (ctrl_mul)
    );

    fxp_pow i_fxp_pow (
        .clk (clk),
        .rst (rst),
        .job (ctrl_pow)
    );

endmodule

// File: verification/fxp_math_unit_tb.sv
// --------------------------------------------------
// Directed and random tests of the Q8.8 math unit
// against a reference model, with back-pressure.
// --------------------------------------------------
module fxp_math_unit_tb;

    // Budget per request is 20 + 19 * exponent cycles.
    localparam int n_mul_dir   = 10;
    localparam int n_pow_dir   = 13;
    localparam int n_random    = 200;
    localparam int n_stall     = 40;
    localparam int cycle_limit = 2 * (26 + n_mul_dir * 20 + n_pow_dir * (20 + 19 * 5)
                                      + n_random * (20 + 19 * 15)
                                      + n_stall * (20 + 19 * 15 + 20));

    logic          clk;
    logic          rst;
    logic          in_valid;
    logic          in_ready;
    logic [0:0]    op;
    fxp_pkg::fxp_t a;
    fxp_pkg::fxp_t b;
    logic          out_valid;
    logic          out_ready;
    fxp_pkg::fxp_t result;

    integer        seed = 32'hf64f;
    int            cycles = 0;

    fxp_math_unit i_fxp_math_unit (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .op        (op),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .result    (result)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > cycle_limit) begin
                $display("Timeout after %0d clock cycles without the tests completing.", cycles);
                $display("Test FAILED");
                $fatal(1, "Simulation timed out");
            end
        end
    end

    // Exact product, arithmetic shift floors, the cast wraps to 16 bits.
    function automatic fxp_pkg::fxp_t mul_model(input fxp_pkg::fxp_t x, input fxp_pkg::fxp_t y);
        longint prod;
        prod = longint'(x) * longint'(y);
        return fxp_pkg::fxp_t'(prod >>> fxp_pkg::frac_width);
    endfunction

    function automatic fxp_pkg::fxp_t pow_model(input fxp_pkg::fxp_t base,
                                                 input fxp_pkg::fxp_t expo);
        fxp_pkg::fxp_exp_t e;
        fxp_pkg::fxp_t     r;
        e = expo[fxp_pkg::fxp_width-1 -: fxp_pkg::int_width];
        r = fxp_pkg::fxp_one;
        for (int i = 0; i < int'(e); i++) begin
            r = mul_model(r, base);
        end
        return r;
    endfunction

    task automatic check_fxp(input string name, input fxp_pkg::fxp_t got,
                             input fxp_pkg::fxp_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            $display("Test FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            $display("Test FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic run_op(input fxp_pkg::fxp_op_e code, input fxp_pkg::fxp_t av,
                          input fxp_pkg::fxp_t bv);
        @(posedge clk);
        in_valid <= 1'b1;
        op       <= code;
        a        <= av;
        b        <= bv;
        @(negedge clk);
        while (!in_ready) @(negedge clk);
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    // Holds out_ready low for stall cycles while the result is pending.
    task automatic collect_result(input int stall, output fxp_pkg::fxp_t res);
        fxp_pkg::fxp_t held;
        @(negedge clk);
        while (!out_valid) @(negedge clk);
        held = result;
        check_flag("in_ready", in_ready, 1'b0);
        repeat (stall) begin
            @(negedge clk);
            check_flag("out_valid", out_valid, 1'b1);
            check_flag("in_ready", in_ready, 1'b0);
            check_fxp("result", result, held);
        end
        @(posedge clk);
        out_ready <= 1'b1;
        // The value on the port at the transfer edge.
        @(negedge clk);
        check_flag("out_valid", out_valid, 1'b1);
        check_fxp("result", result, held);
        @(posedge clk);
        out_ready <= 1'b0;
        // One transfer only, then the unit is idle again.
        @(negedge clk);
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("in_ready", in_ready, 1'b1);
        res = held;
    endtask

    task automatic do_op(input fxp_pkg::fxp_op_e code, input fxp_pkg::fxp_t av,
                         input fxp_pkg::fxp_t bv, input int stall,
                         output fxp_pkg::fxp_t res);
        fxp_pkg::fxp_t expected;
        expected = (code == fxp_pkg::OP_POW) ? pow_model(av, bv) : mul_model(av, bv);
        run_op(code, av, bv);
        collect_result(stall, res);
        check_fxp("result", res, expected);
    endtask

    task automatic test_after_reset();
        rst <= 1'b1;
        repeat (16) begin
            @(posedge clk);
        end
        check_flag("in_ready", in_ready, 1'b0);
        check_flag("out_valid", out_valid, 1'b0);
        rst <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_flag("in_ready", in_ready, 1'b1);
        repeat (10) begin
            @(negedge clk);
            check_flag("out_valid", out_valid, 1'b0);
            check_flag("in_ready", in_ready, 1'b1);
        end
    endtask

    task automatic test_directed_mul();
        fxp_pkg::fxp_t va [n_mul_dir];
        fxp_pkg::fxp_t vb [n_mul_dir];
        fxp_pkg::fxp_t res;
        // Identity, halves, signs, floor rounding, then wrapping overflow.
        va = '{16'h0100, 16'h0100, 16'h0080, 16'hFE80, 16'hFE80,
               16'h0001, 16'hFFFF, 16'h0003, 16'h7F00, 16'h8000};
        vb = '{16'h0340, 16'hFD80, 16'h0080, 16'h0200, 16'hFF40,
               16'h0080, 16'h0080, 16'h0055, 16'h0200, 16'h8000};
        for (int i = 0; i < n_mul_dir; i++) begin
            do_op(fxp_pkg::OP_MUL, va[i], vb[i], 0, res);
        end
    endtask

    task automatic test_directed_pow();
        fxp_pkg::fxp_t     bases [2];
        fxp_pkg::fxp_exp_t exps [4];
        fxp_pkg::fxp_t     res;
        fxp_pkg::fxp_t     res_int;
        bases = '{16'h0180, 16'hFE80};
        exps  = '{8'd0, 8'd1, 8'd2, 8'd5};
        foreach (bases[i]) begin
            foreach (exps[j]) begin
                do_op(fxp_pkg::OP_POW, bases[i], {exps[j], 8'h00}, 0, res);
                if (exps[j] == 8'd0) begin
                    check_fxp("result", res, fxp_pkg::fxp_one);
                end
            end
        end
        // Fractional exponent bits are ignored.
        do_op(fxp_pkg::OP_POW, 16'h0180, 16'h02C0, 0, res);
        do_op(fxp_pkg::OP_POW, 16'h0180, 16'h0200, 0, res_int);
        check_fxp("result", res, res_int);
        do_op(fxp_pkg::OP_POW, 16'hFE80, 16'h05FF, 0, res);
        do_op(fxp_pkg::OP_POW, 16'hFE80, 16'h0500, 0, res_int);
        check_fxp("result", res, res_int);
        do_op(fxp_pkg::OP_POW, 16'h0180, 16'h0040, 0, res);
        check_fxp("result", res, fxp_pkg::fxp_one);
    endtask

    // Random op and operands, power exponents kept to 0 through 15.
    task automatic random_ops(input int count, input logic with_stall);
        logic [31:0]       rnd;
        fxp_pkg::fxp_op_e  code;
        fxp_pkg::fxp_t     av;
        fxp_pkg::fxp_t     bv;
        fxp_pkg::fxp_t     res;
        int                stall;
        for (int i = 0; i < count; i++) begin
            rnd  = $random(seed);
            code = rnd[0] ? fxp_pkg::OP_POW : fxp_pkg::OP_MUL;
            rnd  = $random(seed);
            av   = rnd[15:0];
            bv   = rnd[31:16];
            if (code == fxp_pkg::OP_POW) begin
                bv[15:12] = 4'h0;
            end
            rnd   = $random(seed);
            stall = with_stall ? int'(rnd % 21) : 0;
            do_op(code, av, bv, stall, res);
        end
    endtask

    initial begin
        rst       <= 1'b1;
        in_valid  <= 1'b0;
        op        <= 1'b0;
        a         <= '0;
        b         <= '0;
        out_ready <= 1'b0;
        test_after_reset();
        test_directed_mul();
        test_directed_pow();
        random_ops(n_random, 1'b0);
        random_ops(n_stall, 1'b1);
        $display("Test OK");
        $finish;
    end

endmodule

// File: list.f
hdl/fxp_pkg.sv
hdl/fxp_job_if.sv
hdl/fxp_mul.sv
hdl/fxp_pow.sv
hdl/fxp_math_ctrl.sv
hdl/fxp_math_unit.sv
verification/fxp_math_unit_tb.sv

// File: Makefile
# Verilator build and run for the Q8.8 math unit testbench.

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = fxp_math_unit_tb
FILELIST  = list.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = Test FAILED
PASS_MSG  = Test OK

SOURCES   = $(shell cat $(FILELIST))
SIM_BIN   = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
